// ==== hw/lsfPkg.sv ====
`default_nettype none

package lsfPkg;

  localparam int LINE_BYTES  = 16;
  localparam int BANK_COUNT  = 4;   // 32-bit banks per line
  localparam int LSF_ENTRIES = 4;
  localparam int TAG_WIDTH   = 8;

  typedef logic [27:0]             lineAddrT;  // address above the 16-byte line
  typedef logic [3:0]              byteOffT;   // bank in [3:2]
  typedef logic [LINE_BYTES*8-1:0] lsDataT;
  typedef logic [BANK_COUNT-1:0]   bankMaskT;
  typedef logic [TAG_WIDTH-1:0]    wqTagT;

  // top bit set for a left shift, low bits are the byte count
  typedef logic [4:0] shiftT;

  typedef enum logic [2:0] {
    szByte  = 3'd0,
    szHalf  = 3'd1,
    szWord  = 3'd2,
    szDword = 3'd3,
    szQuad  = 3'd4
  } lsSizeT;

  typedef enum logic [1:0] {
    fwdNone     = 2'd0,  // disjoint or other line
    fwdCover    = 2'd1,  // store holds the whole load
    fwdByBank   = 2'd2,  // load holds a word or larger store
    fwdConflict = 2'd3   // load holds a sub-word store
  } fwdKindT;

  function automatic logic [4:0] sizeBytes(input lsSizeT sz);
    case (sz)
      szByte:  return 5'd1;
      szHalf:  return 5'd2;
      szWord:  return 5'd4;
      szDword: return 5'd8;
      default: return 5'd16;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== hw/lsfAddrCompare.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsfAddrCompare (
  input  logic             clk,
  input  logic             rst,
  input  logic             except,
  input  logic             reqEn,
  input  lsfPkg::lineAddrT reqLine,
  input  lsfPkg::byteOffT  reqOff,
  input  lsfPkg::lsSizeT   reqSize,
  input  lsfPkg::lineAddrT stLine,
  input  lsfPkg::byteOffT  stOff,
  input  lsfPkg::lsSizeT   stSize,
  input  lsfPkg::wqTagT    stTag,
  input  logic             stRdy,
  input  lsfPkg::lsDataT   stData,
  input  logic             wbEn,
  input  lsfPkg::wqTagT    wbTag,
  input  lsfPkg::lsDataT   wbData,
  input  logic             doStall,
  output logic             cmpValid,
  output lsfPkg::fwdKindT  cmpKind,
  output lsfPkg::shiftT    cmpShift,
  output lsfPkg::lsSizeT   cmpSize,
  output lsfPkg::wqTagT    cmpTag,
  output logic             cmpRdy,
  output lsfPkg::lsDataT   cmpData
);

  import lsfPkg::*;

  logic [4:0] ldEnd;  // one past the last load byte
  logic [4:0] stEnd;
  logic       sameLine;
  logic       stHoldsLd;
  logic       ldHoldsSt;
  logic       take;
  logic       wbHit;
  fwdKindT    kind;
  shiftT      shift;

  assign ldEnd = {1'b0, reqOff} + sizeBytes(reqSize);
  assign stEnd = {1'b0, stOff} + sizeBytes(stSize);

  assign sameLine  = reqLine == stLine;
  assign stHoldsLd = (stOff <= reqOff) && (ldEnd <= stEnd);
  assign ldHoldsSt = (reqOff <= stOff) && (stEnd <= ldEnd);

  assign take  = reqEn && !doStall;
  assign wbHit = wbEn && (wbTag == stTag);

  // aligned ranges either nest or miss each other
  always_comb begin
    kind = fwdNone;
    if (sameLine) begin
      if (stHoldsLd) begin
        kind = fwdCover;  // equal ranges land here too
      end else if (ldHoldsSt) begin
        kind = (stSize >= szWord) ? fwdByBank : fwdConflict;
      end
    end
  end

  always_comb begin
    if (reqOff >= stOff) begin
      shift = {1'b0, reqOff - stOff};  // store starts first, move it down
    end else begin
      shift = {1'b1, stOff - reqOff};
    end
  end

  always_ff @(posedge clk) begin
    if (rst || except) begin
      cmpValid <= 1'b0;
    end else begin
      cmpValid <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      cmpKind  <= kind;
      cmpShift <= shift;
      cmpSize  <= reqSize;
      cmpTag   <= stTag;
      cmpRdy   <= stRdy || wbHit;
      cmpData  <= wbHit ? wbData : stData;  // write-back caught this cycle
    end
  end

endmodule

`default_nettype wire

// ==== hw/lsfForwardBuf.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsfForwardBuf (
  input  logic            clk,
  input  logic            rst,
  input  logic            except,
  input  logic            cmpValid,
  input  lsfPkg::fwdKindT cmpKind,
  input  lsfPkg::shiftT   cmpShift,
  input  lsfPkg::lsSizeT  cmpSize,
  input  lsfPkg::wqTagT   cmpTag,
  input  logic            cmpRdy,
  input  lsfPkg::lsDataT  cmpData,
  input  logic            wbEn,
  input  lsfPkg::wqTagT   wbTag,
  input  lsfPkg::lsDataT  wbData,
  input  logic            outPortEn,
  output logic            doStall,
  output logic            popValid,
  output lsfPkg::fwdKindT popKind,
  output lsfPkg::shiftT   popShift,
  output lsfPkg::lsSizeT  popSize,
  output lsfPkg::lsDataT  popData
);

  import lsfPkg::*;

  typedef logic [$clog2(LSF_ENTRIES)-1:0] ptrT;
  typedef logic [$clog2(LSF_ENTRIES):0]   cntT;

  fwdKindT entKind  [LSF_ENTRIES];
  shiftT   entShift [LSF_ENTRIES];
  lsSizeT  entSize  [LSF_ENTRIES];
  wqTagT   entTag   [LSF_ENTRIES];
  lsDataT  entData  [LSF_ENTRIES];

  logic [LSF_ENTRIES-1:0] entRdy;  // store data present
  logic [LSF_ENTRIES-1:0] wbCatch;

  ptrT  head;
  ptrT  tail;
  cntT  count;
  logic pushHit;
  logic pushRdy;
  logic pop;

  assign pushHit = wbEn && (wbTag == cmpTag);

  // no data source needed for these kinds
  assign pushRdy = cmpRdy || pushHit || (cmpKind == fwdNone) || (cmpKind == fwdConflict);

  always_comb begin
    for (int i = 0; i < LSF_ENTRIES; i++) begin
      wbCatch[i] = wbEn && !entRdy[i] && (entTag[i] == wbTag);
    end
  end

  assign pop     = (count != '0) && entRdy[head] && outPortEn;  // oldest only
  assign doStall = (count + cntT'(cmpValid)) >= cntT'(LSF_ENTRIES);

  always_ff @(posedge clk) begin
    if (rst || except) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      popValid <= 1'b0;
    end else begin
      popValid <= pop;
      if (cmpValid) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      count <= count + cntT'(cmpValid) - cntT'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (rst || except) begin
      entRdy <= '0;
    end else begin
      entRdy <= entRdy | wbCatch;
      if (cmpValid) begin
        entRdy[tail] <= pushRdy;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < LSF_ENTRIES; i++) begin
      if (wbCatch[i]) begin
        entData[i] <= wbData;
      end
    end
    if (cmpValid) begin
      entKind[tail]  <= cmpKind;
      entShift[tail] <= cmpShift;
      entSize[tail]  <= cmpSize;
      entTag[tail]   <= cmpTag;
      entData[tail]  <= (pushHit && !cmpRdy) ? wbData : cmpData;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      popKind  <= entKind[head];
      popShift <= entShift[head];
      popSize  <= entSize[head];
      popData  <= entData[head];
    end
  end

endmodule

`default_nettype wire

// ==== hw/lsfDataCombine.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsfDataCombine (
  input  logic             clk,
  input  logic             rst,
  input  logic             except,
  input  logic             popValid,
  input  lsfPkg::fwdKindT  popKind,
  input  lsfPkg::shiftT    popShift,
  input  lsfPkg::lsSizeT   popSize,
  input  lsfPkg::lsDataT   popData,
  output logic             outValid,
  output lsfPkg::fwdKindT  outKind,
  output lsfPkg::lsDataT   outData,
  output lsfPkg::bankMaskT outBnRead
);

  import lsfPkg::*;

  lsDataT     shData;
  lsDataT     sizeMask;
  bankMaskT   bnRead;
  logic [4:0] loadBytes;

  assign loadBytes = sizeBytes(popSize);

  // byte shift of 0 to 15 in either direction
  always_comb begin
    shData = '0;
    for (int k = 0; k < LINE_BYTES; k++) begin
      if (popShift[3:0] == 4'(k)) begin
        shData = popShift[4] ? (popData << (8 * k)) : (popData >> (8 * k));
      end
    end
  end

  always_comb begin
    for (int b = 0; b < LINE_BYTES; b++) begin
      sizeMask[8*b +: 8] = (b < loadBytes) ? 8'hff : 8'h00;
    end
  end

  always_comb begin
    bnRead = '1;
    if (popKind == fwdCover) begin
      bnRead = '0;
    end else if (popKind == fwdByBank) begin
      for (int i = 0; i < BANK_COUNT; i++) begin
        bnRead[i] = (i * (LINE_BYTES / BANK_COUNT)) < popShift[3:0];  // below the store
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || except) begin
      outValid <= 1'b0;
    end else begin
      outValid <= popValid;
    end
  end

  always_ff @(posedge clk) begin
    if (popValid) begin
      outKind   <= popKind;
      outBnRead <= bnRead;
      if ((popKind == fwdCover) || (popKind == fwdByBank)) begin
        outData <= shData & sizeMask;
      end else begin
        outData <= '0;  // all from cache
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/lsfForwardTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsfForwardTop (
  input  logic             clk,
  input  logic             rst,
  input  logic             reqEn,
  input  lsfPkg::lineAddrT reqLine,
  input  lsfPkg::byteOffT  reqOff,
  input  lsfPkg::lsSizeT   reqSize,
  input  lsfPkg::lineAddrT stLine,
  input  lsfPkg::byteOffT  stOff,
  input  lsfPkg::lsSizeT   stSize,
  input  lsfPkg::wqTagT    stTag,
  input  logic             stRdy,
  input  lsfPkg::lsDataT   stData,
  input  logic             wbEn,
  input  lsfPkg::wqTagT    wbTag,
  input  lsfPkg::lsDataT   wbData,
  input  logic             outPortEn,
  input  logic             except,
  output logic             doStall,
  output logic             outValid,
  output lsfPkg::fwdKindT  outKind,
  output lsfPkg::lsDataT   outData,
  output lsfPkg::bankMaskT outBnRead
);

  import lsfPkg::*;

  logic    cmpValid;
  fwdKindT cmpKind;
  shiftT   cmpShift;
  lsSizeT  cmpSize;
  wqTagT   cmpTag;
  logic    cmpRdy;
  lsDataT  cmpData;

  logic    popValid;
  fwdKindT popKind;
  shiftT   popShift;
  lsSizeT  popSize;
  lsDataT  popData;

  lsfAddrCompare u_addrCompare (
    .clk(clk), .rst(rst), .except(except),
    .reqEn(reqEn), .reqLine(reqLine), .reqOff(reqOff), .reqSize(reqSize),
    .stLine(stLine), .stOff(stOff), .stSize(stSize), .stTag(stTag),
    .stRdy(stRdy), .stData(stData),
    .wbEn(wbEn), .wbTag(wbTag), .wbData(wbData),
    .doStall(doStall),  // fed back from the buffer
    .cmpValid(cmpValid), .cmpKind(cmpKind), .cmpShift(cmpShift), .cmpSize(cmpSize),
    .cmpTag(cmpTag), .cmpRdy(cmpRdy), .cmpData(cmpData)
  );

  lsfForwardBuf u_forwardBuf (
    .clk(clk), .rst(rst), .except(except),
    .cmpValid(cmpValid), .cmpKind(cmpKind), .cmpShift(cmpShift), .cmpSize(cmpSize),
    .cmpTag(cmpTag), .cmpRdy(cmpRdy), .cmpData(cmpData),
    .wbEn(wbEn), .wbTag(wbTag), .wbData(wbData),
    .outPortEn(outPortEn),
    .doStall(doStall),
    .popValid(popValid), .popKind(popKind), .popShift(popShift), .popSize(popSize),
    .popData(popData)
  );

  lsfDataCombine u_dataCombine (
    .clk(clk), .rst(rst), .except(except),
    .popValid(popValid), .popKind(popKind), .popShift(popShift), .popSize(popSize),
    .popData(popData),
    .outValid(outValid), .outKind(outKind), .outData(outData), .outBnRead(outBnRead)
  );

endmodule

`default_nettype wire

// ==== sim/lsfForward_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsfForward_props (
  input logic             clk,
  input logic             rst,
  input logic             except,
  input logic             outPortEn,
  input logic             doStall,
  input logic             outValid,
  input lsfPkg::fwdKindT  outKind,
  input lsfPkg::bankMaskT outBnRead
);

  import lsfPkg::*;

  int propFails = 0;

  assert property (@(posedge clk) rst |=> !outValid)
    else begin
      propFails++;
      $error("outValid high right after reset");
    end

  // a covering store needs no cache bank
  assert property (@(posedge clk) disable iff (rst)
                   (outValid && outKind == fwdCover) |-> outBnRead == '0)
    else begin
      propFails++;
      $error("outBnRead not zero for a covering store");
    end

  assert property (@(posedge clk) disable iff (rst)
                   (!outPortEn && !except && doStall) |=> doStall)
    else begin
      propFails++;
      $error("doStall fell with the output port held off");
    end

endmodule

bind lsfForwardTop lsfForward_props u_props (.*);

`default_nettype wire

// ==== include/lsfTbTasks.svh ====
`ifndef LSF_TB_TASKS_SVH
`define LSF_TB_TASKS_SVH

task automatic abortRun(input string why);
  $display("%s", why);
  $display("Testbench failed");
  $fatal(1);
endtask

task automatic checkEq(input string what, input logic [127:0] got, input logic [127:0] exp);
  if (got !== exp) begin
    abortRun($sformatf("ERR t=%0t %s mismatch, got %0h expected %0h",
                       $time, what, got, exp));
  end
endtask

function automatic int byteCount(input lsSizeT sz);
  return 1 << int'(sz);  // 1, 2, 4, 8, 16
endfunction

function automatic lsDataT randLine();
  return {$urandom, $urandom, $urandom, $urandom};
endfunction

// expected kind, data and bank mask of one load
function automatic expT predict(input lineAddrT ldLine, input byteOffT ldOff,
                                input lsSizeT ldSz, input lineAddrT sLine,
                                input byteOffT sOff, input lsSizeT sSz, input lsDataT data);
  int     ldB;
  int     stB;
  int     d;
  lsDataT mask;
  expT    e;
  ldB    = byteCount(ldSz);
  stB    = byteCount(sSz);
  d      = int'(ldOff) - int'(sOff);
  e.kind = fwdNone;
  e.data = '0;
  e.bn   = '1;
  mask   = '0;
  for (int b = 0; b < ldB; b++) begin
    mask[8*b +: 8] = 8'hff;
  end
  if (ldLine == sLine) begin
    if (d >= 0 && d + ldB <= stB) begin
      e.kind = fwdCover;
    end else if (d <= 0 && stB - d <= ldB) begin
      e.kind = (stB >= 4) ? fwdByBank : fwdConflict;
    end
  end
  if (e.kind == fwdCover) begin
    e.data = (data >> (8 * d)) & mask;
    e.bn   = '0;
  end else if (e.kind == fwdByBank) begin
    e.data = (data << (8 * -d)) & mask;
    for (int i = 0; i < 4; i++) begin
      e.bn[i] = !((4 * i < stB - d) && (-d < 4 * i + 4));  // bank misses the store bytes
    end
  end
  return e;
endfunction

// called on a falling edge, leaves the request up
task automatic driveReq(input lineAddrT ldLine, input byteOffT ldOff, input lsSizeT ldSz,
                        input lineAddrT sLine, input byteOffT sOff, input lsSizeT sSz,
                        input wqTagT tag, input logic rdy, input lsDataT data,
                        input lsDataT fwdData);
  reqEn   = 1'b1;
  reqLine = ldLine;
  reqOff  = ldOff;
  reqSize = ldSz;
  stLine  = sLine;
  stOff   = sOff;
  stSize  = sSz;
  stTag   = tag;
  stRdy   = rdy;
  stData  = data;
  sb.push_back(predict(ldLine, ldOff, ldSz, sLine, sOff, sSz, fwdData));
endtask

task automatic waitTaken();
  while (doStall) @(negedge clk);  // hold during the stall
  @(negedge clk);
  reqEn = 1'b0;
endtask

task automatic sendReq(input lineAddrT ldLine, input byteOffT ldOff, input lsSizeT ldSz,
                       input lineAddrT sLine, input byteOffT sOff, input lsSizeT sSz,
                       input wqTagT tag, input logic rdy, input lsDataT data,
                       input lsDataT fwdData);
  driveReq(ldLine, ldOff, ldSz, sLine, sOff, sSz, tag, rdy, data, fwdData);
  waitTaken();
endtask

task automatic sendWb(input wqTagT tag, input lsDataT data);
  wbEn   = 1'b1;
  wbTag  = tag;
  wbData = data;
  @(negedge clk);
  wbEn = 1'b0;
endtask

task automatic idleCheck(input int n);
  repeat (n) begin
    @(negedge clk);
    checkEq("outValid while idle", outValid, 1'b0);
  end
endtask

task automatic drain();
  while (sb.size() != 0) @(negedge clk);
endtask

task automatic testCover();
  lineAddrT ln;
  lsDataT   d;
  int       b;
  for (int s = 0; s < 5; s++) begin
    ln = lineAddrT'($urandom);
    d  = randLine();
    b  = 1 << s;
    sendReq(ln, byteOffT'(LINE_BYTES - b), lsSizeT'(s), ln, 4'd0, szQuad, 8'h01, 1'b1, d, d);
    repeat (2) begin
      @(negedge clk);
      checkEq("outValid before latency 3", outValid, 1'b0);
    end
    @(negedge clk);
    checkEq("outValid at latency 3", outValid, 1'b1);
  end
endtask

task automatic testByBank();
  lineAddrT ln;
  lsDataT   d;
  ln = lineAddrT'($urandom);
  d  = randLine();
  sendReq(ln, 4'd0, szQuad, ln, 4'd12, szWord, 8'h02, 1'b1, d, d);
  d = randLine();
  sendReq(ln, 4'd0, szQuad, ln, 4'd8, szDword, 8'h03, 1'b1, d, d);
  drain();
endtask

task automatic testNoForward();
  lineAddrT ln;
  lsDataT   d;
  ln = lineAddrT'($urandom);
  d  = randLine();
  sendReq(ln, 4'd4, szWord, ln ^ 28'h1, 4'd0, szQuad, 8'h04, 1'b1, d, d);
  sendReq(ln, 4'd0, szWord, ln, 4'd8, szWord, 8'h05, 1'b0, d, d);  // disjoint
  sendReq(ln, 4'd4, szWord, ln, 4'd5, szByte, 8'h06, 1'b0, d, d);  // sub-word store
  drain();
endtask

task automatic testLateWb();
  lineAddrT ln;
  lsDataT   wd [3];
  ln = lineAddrT'($urandom);
  for (int i = 0; i < 3; i++) begin
    wd[i] = randLine();
    sendReq(ln, 4'd4, szWord, ln, 4'd4, szWord, wqTagT'(8'h10 + i), 1'b0, randLine(), wd[i]);
  end
  idleCheck(3);
  sendWb(8'h12, wd[2]);
  sendWb(8'h10, wd[0]);
  sendWb(8'h11, wd[1]);
  drain();
endtask

task automatic testBackPressure();
  lineAddrT ln;
  lsDataT   d;
  outPortEn = 1'b0;
  ln = lineAddrT'($urandom);
  for (int i = 0; i < 4; i++) begin
    d = randLine();
    sendReq(ln, byteOffT'(4 * i), szWord, ln, 4'd0, szQuad, 8'h20, 1'b1, d, d);
  end
  checkEq("doStall with full buffer", doStall, 1'b1);
  d = randLine();
  driveReq(ln, 4'd2, szHalf, ln, 4'd0, szQuad, 8'h21, 1'b1, d, d);
  idleCheck(4);
  checkEq("doStall while held", doStall, 1'b1);
  outPortEn = 1'b1;
  waitTaken();
  drain();
endtask

task automatic testExcept();
  lineAddrT ln;
  lsDataT   d;
  ln = lineAddrT'($urandom);
  for (int i = 0; i < 3; i++) begin
    d = randLine();
    sendReq(ln, 4'd0, szDword, ln, 4'd0, szQuad, wqTagT'(8'h30 + i), 1'b0, d, d);
  end
  except = 1'b1;  // last load still in stage 1
  @(posedge clk);
  sb.delete();
  @(negedge clk);
  except = 1'b0;
  sendWb(8'h30, d);
  idleCheck(4);
  for (int i = 0; i < 2; i++) begin
    d = randLine();
    sendReq(ln, 4'd8, szWord, ln, 4'd8, szDword, 8'h38, 1'b1, d, d);
  end
  drain();
endtask

`endif

// ==== sim/lsfForwardTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsfForwardTb;

  import lsfPkg::*;

  // six directed tests need well under 150 cycles
  localparam int MAX_CYCLES = 400;

  typedef struct packed {
    fwdKindT  kind;
    lsDataT   data;
    bankMaskT bn;
  } expT;

  logic     clk;
  logic     rst;
  logic     reqEn;
  lineAddrT reqLine;
  byteOffT  reqOff;
  lsSizeT   reqSize;
  lineAddrT stLine;
  byteOffT  stOff;
  lsSizeT   stSize;
  wqTagT    stTag;
  logic     stRdy;
  lsDataT   stData;
  logic     wbEn;
  wqTagT    wbTag;
  lsDataT   wbData;
  logic     outPortEn;
  logic     except;
  logic     doStall;
  logic     outValid;
  fwdKindT  outKind;
  lsDataT   outData;
  bankMaskT outBnRead;

  expT sb[$];  // predicted results in load order
  int  cycles;

  lsfForwardTop u_lsfForwardTop (.*);

  `include "lsfTbTasks.svh"

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    abortRun("timeout: the tests did not finish within the cycle limit");
  end

  always @(negedge clk) begin : monitor
    expT e;
    if (u_lsfForwardTop.u_props.propFails != 0) begin
      abortRun("a bound assertion on the top-level outputs failed");
    end else if (!rst && outValid) begin
      if (sb.size() == 0) begin
        abortRun("outValid was seen with no load outstanding");
      end else begin
        e = sb.pop_front();
        checkEq("outKind", outKind, e.kind);
        checkEq("outData", outData, e.data);
        checkEq("outBnRead", outBnRead, e.bn);
      end
    end
  end

  initial begin
    void'($urandom(88));
    rst       = 1'b1;
    reqEn     = 1'b0;
    reqLine   = '0;
    reqOff    = '0;
    reqSize   = szByte;
    stLine    = '0;
    stOff     = '0;
    stSize    = szByte;
    stTag     = '0;
    stRdy     = 1'b0;
    stData    = '0;
    wbEn      = 1'b0;
    wbTag     = '0;
    wbData    = '0;
    outPortEn = 1'b1;
    except    = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    testCover();
    testByBank();
    testNoForward();
    testLateWb();
    testBackPressure();
    testExcept();
    idleCheck(4);

    if (u_lsfForwardTop.u_props.propFails != 0) begin
      abortRun("a bound assertion on the top-level outputs failed");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
hw/lsfPkg.sv
hw/lsfAddrCompare.sv
hw/lsfForwardBuf.sv
hw/lsfDataCombine.sv
hw/lsfForwardTop.sv
sim/lsfForward_props.sv
sim/lsfForwardTb.sv

// ==== Bender.yml ====
package:
  name: lsf_forward

sources:
  - hw/lsfPkg.sv
  - hw/lsfAddrCompare.sv
  - hw/lsfForwardBuf.sv
  - hw/lsfDataCombine.sv
  - hw/lsfForwardTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/lsfForward_props.sv
      - sim/lsfForwardTb.sv
